// ==== verilog/soc_map_pkg.sv ====
package soc_map_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LANES  = 4;            // Byte lanes per data word

  // --------------------
  // Slot field
  // --------------------
  localparam int NUM_SLOTS = 9;
  localparam int SLOT_W    = 4;         // Slot index bits 19:16
  localparam int SLOT_LSB  = 16;        // 64 KB per slot

  // Upper address bits shared by every slot, bits 31:20
  localparam logic [ADDR_W-SLOT_LSB-SLOT_W-1:0] REGION_BASE = 12'h008;

  // Slot numbers, same order as the bridge ranges
  localparam int SLOT_SPI   = 0;
  localparam int SLOT_UART0 = 1;        // Byte-wide registers
  localparam int SLOT_GPIO  = 2;
  localparam int SLOT_TTC   = 3;
  localparam int SLOT_SMC   = 5;
  localparam int SLOT_PMC   = 6;        // Power controller, internal
  localparam int SLOT_UART1 = 8;        // Byte-wide registers

  // Holes in the map, slots 4 and 7
  // Answer ready with zero data, no select
  localparam logic [NUM_SLOTS-1:0] UNMAPPED_SLOTS = ~(
    (NUM_SLOTS'(1) << SLOT_SPI)   |
    (NUM_SLOTS'(1) << SLOT_UART0) |
    (NUM_SLOTS'(1) << SLOT_GPIO)  |
    (NUM_SLOTS'(1) << SLOT_TTC)   |
    (NUM_SLOTS'(1) << SLOT_SMC)   |
    (NUM_SLOTS'(1) << SLOT_PMC)   |
    (NUM_SLOTS'(1) << SLOT_UART1)
  );

endpackage

// ==== verilog/pwr_pkg.sv ====
package pwr_pkg;

  // --------------------
  // Power domains
  // --------------------
  localparam int NUM_DOMAINS = 6;
  localparam int DOM_SMC     = 0;       // Static memory controller
  localparam int DOM_URT     = 1;       // UART pair
  localparam int DOM_MACB0   = 2;       // First Ethernet domain
  localparam int DOM_MACB1   = 3;
  localparam int DOM_MACB2   = 4;
  localparam int DOM_MACB3   = 5;       // Last Ethernet domain

  // --------------------
  // Interrupt vector
  // --------------------
  // Bit 0 SPI, 1 UART1, 2 UART0, 3 GPIO
  // Bits 4 to 6 timer lines, 7 DMA
  // Bits 8 to 11 Ethernet MACs
  localparam int NUM_IRQ  = 12;
  localparam int IRQ_GPIO = 3;          // Only source that ends hibernation

  // --------------------
  // Register map
  // --------------------
  // Offsets within the 64 KB slot
  localparam logic [15:0] PMC_CTRL_OFS = 16'h0000;
  localparam logic [15:0] PMC_STAT_OFS = 16'h0004;

  // CTRL layout
  // Bits NUM_DOMAINS-1:0 gate requests, one per domain
  localparam int CTRL_ISO_BIT = 8;      // isolate_mem, hibernation

  // STAT layout
  localparam int STAT_WAKE_BIT = 0;     // Sticky Ethernet wake, write 1 clears

endpackage

// ==== verilog/apb_slave_if.sv ====
interface apb_slave_if;

  logic [soc_map_pkg::ADDR_W-1:0] paddr;
  logic                           psel;
  logic                           penable;   // Access phase
  logic                           pwrite;
  logic [soc_map_pkg::DATA_W-1:0] pwdata;
  logic [soc_map_pkg::DATA_W-1:0] prdata;
  logic                           pready;

  // Decode side
  modport master (
    output paddr,
    output psel,
    output penable,
    output pwrite,
    output pwdata,
    input  prdata,
    input  pready
  );

  // Peripheral side
  modport slave (
    input  paddr,
    input  psel,
    input  penable,
    input  pwrite,
    input  pwdata,
    output prdata,
    output pready
  );

endinterface

// ==== verilog/apb_slot_mux.sv ====
module apb_slot_mux #(
  parameter bit BIG_ENDIAN = 1'b0       // Lane 0 at the top byte when set
) (
  input  logic [soc_map_pkg::ADDR_W-1:0]                            i_paddr,
  input  logic                                                      i_psel,
  input  logic                                                      i_penable,
  input  logic                                                      i_pwrite,
  input  logic [soc_map_pkg::DATA_W-1:0]                            i_pwdata,
  input  logic [soc_map_pkg::NUM_SLOTS-1:0][soc_map_pkg::DATA_W-1:0] i_slot_prdata,
  input  logic [soc_map_pkg::NUM_SLOTS-1:0]                         i_slot_pready,
  output logic [soc_map_pkg::NUM_SLOTS-1:0]                         o_slot_sel,
  output logic [soc_map_pkg::DATA_W-1:0]                            o_prdata,
  output logic                                                      o_pready,
  output logic                                                      o_pslverr,
  output logic [soc_map_pkg::LANES-1:0]                             o_byte_sel,
  apb_slave_if.master                                               pmc
);

  logic [soc_map_pkg::SLOT_W-1:0]    slot_idx;
  logic                              region_hit;
  logic                              in_range;
  logic [soc_map_pkg::NUM_SLOTS-1:0] slot_hit;   // Address decode, no psel
  logic [soc_map_pkg::NUM_SLOTS-1:0] sel_all;    // Selects including PMC
  logic [soc_map_pkg::NUM_SLOTS-1:0][soc_map_pkg::DATA_W-1:0] rdata_arr;
  logic [soc_map_pkg::NUM_SLOTS-1:0] ready_arr;
  logic [soc_map_pkg::LANES-1:0]     lane_le;

  // --------------------
  // Address decode
  // --------------------
  assign slot_idx   = i_paddr[soc_map_pkg::SLOT_LSB +: soc_map_pkg::SLOT_W];
  assign region_hit = (i_paddr[soc_map_pkg::ADDR_W-1:soc_map_pkg::SLOT_LSB+soc_map_pkg::SLOT_W]
                       == soc_map_pkg::REGION_BASE);
  assign in_range   = region_hit && (int'(slot_idx) < soc_map_pkg::NUM_SLOTS);

  always_comb begin
    for (int s = 0; s < soc_map_pkg::NUM_SLOTS; s++) begin
      slot_hit[s] = in_range && (int'(slot_idx) == s);
    end
  end

  // Holes never get a select
  assign sel_all = slot_hit & ~soc_map_pkg::UNMAPPED_SLOTS
                   & {soc_map_pkg::NUM_SLOTS{i_psel}};

  always_comb begin
    o_slot_sel                        = sel_all;
    o_slot_sel[soc_map_pkg::SLOT_PMC] = 1'b0;     // PMC stays inside
  end

  // Shared request lines toward the power controller
  assign pmc.psel    = sel_all[soc_map_pkg::SLOT_PMC];
  assign pmc.paddr   = i_paddr;
  assign pmc.penable = i_penable;
  assign pmc.pwrite  = i_pwrite;
  assign pmc.pwdata  = i_pwdata;

  // --------------------
  // Read return
  // --------------------
  always_comb begin
    for (int s = 0; s < soc_map_pkg::NUM_SLOTS; s++) begin
      if (s == soc_map_pkg::SLOT_PMC) begin
        rdata_arr[s] = pmc.prdata;
        ready_arr[s] = pmc.pready;
      end else if (soc_map_pkg::UNMAPPED_SLOTS[s]) begin
        rdata_arr[s] = '0;                        // Empty slot reads zero
        ready_arr[s] = 1'b1;
      end else begin
        rdata_arr[s] = i_slot_prdata[s];
        ready_arr[s] = i_slot_pready[s];          // Slot may stretch the access
      end
    end
  end

  always_comb begin
    o_prdata = '0;                                // Out of range, zero data
    o_pready = 1'b1;                              // and no wait states
    for (int s = 0; s < soc_map_pkg::NUM_SLOTS; s++) begin
      if (slot_hit[s]) begin
        o_prdata = rdata_arr[s];
        o_pready = ready_arr[s];
      end
    end
  end

  assign o_pslverr = i_psel && !in_range;        // Outside region or past slot 8

  // --------------------
  // UART byte lanes
  // --------------------
  always_comb begin
    lane_le = '0;
    lane_le[i_paddr[$clog2(soc_map_pkg::LANES)-1:0]] = 1'b1;
    for (int l = 0; l < soc_map_pkg::LANES; l++) begin
      o_byte_sel[l] = BIG_ENDIAN ? lane_le[soc_map_pkg::LANES-1-l] : lane_le[l];
    end
  end

  // External and PMC selects together at most one-hot
  always_comb begin
    assert ($onehot0({o_slot_sel, pmc.psel}))
      else $error("apb_slot_mux: more than one slot selected");
  end

endmodule

// ==== verilog/power_ctrl.sv ====
module power_ctrl (
  input  logic                                         i_pclk,
  input  logic                                         i_reset,
  input  logic [pwr_pkg::NUM_IRQ-1:0]                  i_irq,
  input  logic [pwr_pkg::DOM_MACB3:pwr_pkg::DOM_MACB0] i_macb_wakeup,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]              o_gate_req,
  output logic                                         o_isolate_mem,
  output logic                                         o_pcm_irq,
  apb_slave_if.slave                                   bus
);

  logic [soc_map_pkg::SLOT_LSB-1:0]  reg_ofs;
  logic                              ctrl_hit;
  logic                              stat_hit;
  logic                              wr_access;
  logic                              ctrl_wr;
  logic                              stat_wr;
  logic                              wake;
  logic                              macb_wake_hit;
  logic [pwr_pkg::NUM_DOMAINS-1:0]   gate_q;
  logic                              iso_q;
  logic                              wake_irq_q;
  logic [soc_map_pkg::DATA_W-1:0]    ctrl_word;
  logic [soc_map_pkg::DATA_W-1:0]    stat_word;

  // --------------------
  // Register access
  // --------------------
  assign reg_ofs  = bus.paddr[soc_map_pkg::SLOT_LSB-1:0];
  assign ctrl_hit = (reg_ofs == pwr_pkg::PMC_CTRL_OFS);
  assign stat_hit = (reg_ofs == pwr_pkg::PMC_STAT_OFS);

  // No wait states, so access phase always completes
  assign wr_access = bus.psel && bus.penable && bus.pwrite;
  assign ctrl_wr   = wr_access && ctrl_hit;
  assign stat_wr   = wr_access && stat_hit;

  assign bus.pready = 1'b1;

  // --------------------
  // Wake detection
  // --------------------
  // Sleep: any interrupt, own wake interrupt included
  // Hibernation: GPIO only
  assign wake = o_isolate_mem ? i_irq[pwr_pkg::IRQ_GPIO]
                              : (|i_irq || wake_irq_q);

  // Ethernet wakeup counts only for a gated MAC domain
  assign macb_wake_hit = |(i_macb_wakeup & gate_q[pwr_pkg::DOM_MACB3:pwr_pkg::DOM_MACB0]);

  always_ff @(posedge i_pclk) begin
    if (i_reset) begin
      gate_q     <= '0;
      iso_q      <= 1'b0;
      wake_irq_q <= 1'b0;
    end else begin
      if (wake) begin
        gate_q <= '0;                             // Wake beats a CTRL write
        iso_q  <= 1'b0;
      end else if (ctrl_wr) begin
        gate_q <= bus.pwdata[pwr_pkg::NUM_DOMAINS-1:0];
        iso_q  <= bus.pwdata[pwr_pkg::CTRL_ISO_BIT];
      end

      if (macb_wake_hit) begin
        wake_irq_q <= 1'b1;                       // Set wins over clear
      end else if (stat_wr && bus.pwdata[pwr_pkg::STAT_WAKE_BIT]) begin
        wake_irq_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Read data
  // --------------------
  always_comb begin
    ctrl_word                                = '0;
    ctrl_word[pwr_pkg::NUM_DOMAINS-1:0]      = gate_q;
    ctrl_word[pwr_pkg::CTRL_ISO_BIT]         = iso_q;
    stat_word                                = '0;
    stat_word[pwr_pkg::STAT_WAKE_BIT]        = wake_irq_q;
  end

  always_comb begin
    if (ctrl_hit) begin
      bus.prdata = ctrl_word;
    end else if (stat_hit) begin
      bus.prdata = stat_word;
    end else begin
      bus.prdata = '0;                            // Unused offsets
    end
  end

  assign o_gate_req    = gate_q;
  assign o_isolate_mem = iso_q;
  assign o_pcm_irq     = wake_irq_q;

  // Every domain ungated the cycle after a wake
  a_wake_clears_gates : assert property (
    @(posedge i_pclk) disable iff (i_reset)
    wake |=> (o_gate_req == '0)
  ) else $error("power_ctrl: gate request survived a wake");

endmodule

// ==== verilog/clk_gate_bank.sv ====
module clk_gate_bank (
  input  logic                            i_pclk,
  input  logic                            i_scan_mode,
  input  logic [pwr_pkg::NUM_DOMAINS-1:0] i_gate_req,
  output logic [pwr_pkg::NUM_DOMAINS-1:0] o_clk_en
);

  logic [pwr_pkg::NUM_DOMAINS-1:0] en_d;

  // Scan forces every domain on
  assign en_d = {pwr_pkg::NUM_DOMAINS{i_scan_mode}} | ~i_gate_req;

  // --------------------
  // Enable latches
  // --------------------
  // Open while the clock is low, closed across the high phase
  // so the enable never changes under a high clock
  for (genvar d = 0; d < pwr_pkg::NUM_DOMAINS; d++) begin : g_dom
    always_latch begin
      if (!i_pclk) begin
        o_clk_en[d] <= en_d[d];
      end
    end
  end

  // Scan mode seen at the edge means the low phase before it had all enables on
  a_scan_all_on : assert property (
    @(posedge i_pclk)
    i_scan_mode |-> (&o_clk_en)
  ) else $error("clk_gate_bank: domain clock off in scan mode");

endmodule

// ==== verilog/apb_subsystem.sv ====
module apb_subsystem #(
  parameter bit BIG_ENDIAN = 1'b0
) (
  input  logic                                                      i_pclk,
  input  logic                                                      i_reset,
  // Bus from the bridge
  input  logic [soc_map_pkg::ADDR_W-1:0]                            i_paddr,
  input  logic                                                      i_psel,
  input  logic                                                      i_penable,
  input  logic                                                      i_pwrite,
  input  logic [soc_map_pkg::DATA_W-1:0]                            i_pwdata,
  output logic [soc_map_pkg::DATA_W-1:0]                            o_prdata,
  output logic                                                      o_pready,
  output logic                                                      o_pslverr,
  // External slots
  input  logic [soc_map_pkg::NUM_SLOTS-1:0][soc_map_pkg::DATA_W-1:0] i_slot_prdata,
  input  logic [soc_map_pkg::NUM_SLOTS-1:0]                         i_slot_pready,
  output logic [soc_map_pkg::NUM_SLOTS-1:0]                         o_slot_sel,
  output logic [soc_map_pkg::LANES-1:0]                             o_byte_sel,
  output logic [soc_map_pkg::ADDR_W-1:0]                            o_paddr,
  output logic                                                      o_pwrite,
  output logic [soc_map_pkg::DATA_W-1:0]                            o_pwdata,
  output logic                                                      o_penable,
  // Power management
  input  logic [pwr_pkg::NUM_IRQ-1:0]                               i_irq,
  input  logic [pwr_pkg::DOM_MACB3:pwr_pkg::DOM_MACB0]              i_macb_wakeup,
  input  logic                                                      i_scan_mode,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]                           o_clk_en,
  output logic                                                      o_isolate_mem,
  output logic                                                      o_pcm_irq
);

  logic [pwr_pkg::NUM_DOMAINS-1:0] gate_req;

  apb_slave_if pmc_bus ();               // Decode to power controller

  // Same request lines for every external slot
  assign o_paddr   = i_paddr;
  assign o_pwrite  = i_pwrite;
  assign o_pwdata  = i_pwdata;
  assign o_penable = i_penable;

  // --------------------
  // Instances
  // --------------------
  apb_slot_mux #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_slot_mux (
    .i_paddr       (i_paddr),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_pwdata      (i_pwdata),
    .i_slot_prdata (i_slot_prdata),
    .i_slot_pready (i_slot_pready),
    .o_slot_sel    (o_slot_sel),
    .o_prdata      (o_prdata),
    .o_pready      (o_pready),
    .o_pslverr     (o_pslverr),
    .o_byte_sel    (o_byte_sel),
    .pmc           (pmc_bus)
  );

  power_ctrl u_power_ctrl (
    .i_pclk        (i_pclk),
    .i_reset       (i_reset),
    .i_irq         (i_irq),
    .i_macb_wakeup (i_macb_wakeup),
    .o_gate_req    (gate_req),
    .o_isolate_mem (o_isolate_mem),
    .o_pcm_irq     (o_pcm_irq),
    .bus           (pmc_bus)
  );

  clk_gate_bank u_clk_gate_bank (
    .i_pclk      (i_pclk),
    .i_scan_mode (i_scan_mode),
    .i_gate_req  (gate_req),
    .o_clk_en    (o_clk_en)            // Enables only, gating done per domain
  );

endmodule

// ==== verif/tb_apb_subsystem.sv ====
module tb_apb_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 400;       // Tests need about 140 cycles

  logic                                                      pclk;
  logic                                                      reset;
  logic [soc_map_pkg::ADDR_W-1:0]                            paddr;
  logic                                                      psel;
  logic                                                      penable;
  logic                                                      pwrite;
  logic [soc_map_pkg::DATA_W-1:0]                            pwdata;
  logic [soc_map_pkg::NUM_SLOTS-1:0][soc_map_pkg::DATA_W-1:0] slot_prdata;
  logic [soc_map_pkg::NUM_SLOTS-1:0]                         slot_pready;
  logic [pwr_pkg::NUM_IRQ-1:0]                               irq;
  logic [pwr_pkg::DOM_MACB3:pwr_pkg::DOM_MACB0]              macb_wakeup;
  logic                                                      scan_mode;
  logic [soc_map_pkg::DATA_W-1:0]                            o_prdata;
  logic                                                      o_pready;
  logic                                                      o_pslverr;
  logic [soc_map_pkg::NUM_SLOTS-1:0]                         o_slot_sel;
  logic [soc_map_pkg::LANES-1:0]                             o_byte_sel;
  logic [soc_map_pkg::ADDR_W-1:0]                            o_paddr;
  logic                                                      o_pwrite;
  logic [soc_map_pkg::DATA_W-1:0]                            o_pwdata;
  logic                                                      o_penable;
  logic [pwr_pkg::NUM_DOMAINS-1:0]                           o_clk_en;
  logic                                                      o_isolate_mem;
  logic                                                      o_pcm_irq;

  // Reference state of the power controller
  logic [pwr_pkg::NUM_DOMAINS-1:0] m_gate;
  logic                            m_iso;
  logic                            m_wirq;
  logic                            m_wake;
  logic                            pmc_wr;

  int          errors;
  int          errors_at_start;
  int          test_num;
  int          tests_failed;
  int          cycles;
  logic [31:0] lcg_state;

  apb_subsystem uut (
    .i_pclk (pclk), .i_reset (reset),
    .i_paddr (paddr), .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
    .i_pwdata (pwdata), .o_prdata (o_prdata), .o_pready (o_pready), .o_pslverr (o_pslverr),
    .i_slot_prdata (slot_prdata), .i_slot_pready (slot_pready), .o_slot_sel (o_slot_sel),
    .o_byte_sel (o_byte_sel), .o_paddr (o_paddr), .o_pwrite (o_pwrite),
    .o_pwdata (o_pwdata), .o_penable (o_penable),
    .i_irq (irq), .i_macb_wakeup (macb_wakeup), .i_scan_mode (scan_mode),
    .o_clk_en (o_clk_en), .o_isolate_mem (o_isolate_mem), .o_pcm_irq (o_pcm_irq)
  );

  always #10 pclk = ~pclk;               // 20 ns period

  // --------------------
  // Address map rules
  // --------------------
  function automatic logic [31:0] slot_addr(int s, logic [15:0] ofs);
    return {soc_map_pkg::REGION_BASE, 4'(s), ofs};
  endfunction

  // Slot model data from slot number and offset
  function automatic logic [31:0] slot_word(int s, logic [15:0] ofs);
    return {4'hA, 4'(s), 8'h5C, ofs};
  endfunction

  function automatic logic addr_err(logic [31:0] a);
    return (a[31:20] != soc_map_pkg::REGION_BASE)
           || (int'(a[19:16]) >= soc_map_pkg::NUM_SLOTS);
  endfunction

  function automatic logic is_external(logic [31:0] a);   // Mapped and outside the PMC
    int s;
    s = int'(a[19:16]);
    if (addr_err(a)) return 1'b0;
    return !soc_map_pkg::UNMAPPED_SLOTS[s] && (s != soc_map_pkg::SLOT_PMC);
  endfunction

  function automatic logic is_pmc(logic [31:0] a);
    return !addr_err(a) && (int'(a[19:16]) == soc_map_pkg::SLOT_PMC);
  endfunction

  function automatic logic [soc_map_pkg::NUM_SLOTS-1:0] exp_sel(logic [31:0] a);
    if (!is_external(a)) return '0;
    return soc_map_pkg::NUM_SLOTS'(1) << a[19:16];
  endfunction

  function automatic logic exp_ready(logic [31:0] a, logic [soc_map_pkg::NUM_SLOTS-1:0] rdy);
    if (!is_external(a)) return 1'b1;      // Holes, PMC and errors never wait
    return rdy[a[19:16]];
  endfunction

  function automatic logic [31:0] exp_rdata(logic [31:0] a,
                                            logic [pwr_pkg::NUM_DOMAINS-1:0] gate,
                                            logic iso, logic wirq);
    logic [31:0] r;
    r = '0;
    if (is_external(a)) begin
      r = slot_word(int'(a[19:16]), a[15:0]);
    end else if (is_pmc(a) && a[15:0] == pwr_pkg::PMC_CTRL_OFS) begin
      r[pwr_pkg::NUM_DOMAINS-1:0] = gate;
      r[pwr_pkg::CTRL_ISO_BIT]    = iso;
    end else if (is_pmc(a) && a[15:0] == pwr_pkg::PMC_STAT_OFS) begin
      r[pwr_pkg::STAT_WAKE_BIT] = wirq;
    end
    return r;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  always_comb begin
    for (int s = 0; s < soc_map_pkg::NUM_SLOTS; s++) begin
      slot_prdata[s] = slot_word(s, paddr[15:0]);
    end
  end

  // --------------------
  // Power controller reference
  // --------------------
  assign pmc_wr = psel && penable && pwrite && is_pmc(paddr);
  assign m_wake = m_iso ? irq[pwr_pkg::IRQ_GPIO] : (|irq || m_wirq);  // Hibernation wakes on GPIO

  always @(posedge pclk) begin
    if (reset) begin
      m_gate <= '0;
      m_iso  <= 1'b0;
      m_wirq <= 1'b0;
    end else begin
      if (m_wake) begin
        m_gate <= '0;
        m_iso  <= 1'b0;
      end else if (pmc_wr && paddr[15:0] == pwr_pkg::PMC_CTRL_OFS) begin
        m_gate <= pwdata[pwr_pkg::NUM_DOMAINS-1:0];
        m_iso  <= pwdata[pwr_pkg::CTRL_ISO_BIT];
      end
      if (|(macb_wakeup & m_gate[pwr_pkg::DOM_MACB3:pwr_pkg::DOM_MACB0])) begin
        m_wirq <= 1'b1;
      end else if (pmc_wr && paddr[15:0] == pwr_pkg::PMC_STAT_OFS
                   && pwdata[pwr_pkg::STAT_WAKE_BIT]) begin
        m_wirq <= 1'b0;                    // Write 1 clears
      end
    end
  end

  task automatic report_mismatch(string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  // --------------------
  // Checks
  // --------------------
  // No select at all while psel is low
  a_slot_sel : assert property (@(posedge pclk) disable iff (reset)
    o_slot_sel == (psel ? exp_sel(paddr) : '0))
    else report_mismatch($sformatf("o_slot_sel %b for address %h", o_slot_sel, paddr));
  a_slverr : assert property (@(posedge pclk) disable iff (reset)
    o_pslverr == (psel && addr_err(paddr)))
    else report_mismatch($sformatf("o_pslverr %b for address %h", o_pslverr, paddr));
  a_ready : assert property (@(posedge pclk) disable iff (reset)
    psel |-> (o_pready == exp_ready(paddr, slot_pready)))
    else report_mismatch($sformatf("o_pready %b for address %h", o_pready, paddr));
  a_rdata : assert property (@(posedge pclk) disable iff (reset)
    (psel && penable && !pwrite && o_pready)
      |-> (o_prdata == exp_rdata(paddr, m_gate, m_iso, m_wirq)))
    else report_mismatch($sformatf("o_prdata %h for address %h", o_prdata, paddr));
  a_byte_sel : assert property (@(posedge pclk) disable iff (reset)
    psel |-> (o_byte_sel == (4'b0001 << paddr[1:0])))
    else report_mismatch($sformatf("o_byte_sel %b for address %h", o_byte_sel, paddr));
  a_shared_bus : assert property (@(posedge pclk) disable iff (reset)
    (o_paddr == paddr) && (o_pwdata == pwdata) && (o_pwrite == pwrite)
    && (o_penable == penable))
    else report_mismatch("shared slot bus differs from the master bus");
  // Gate bits from the previous edge with scan forcing all on
  a_clk_en : assert property (@(posedge pclk) disable iff (reset)
    o_clk_en == ({pwr_pkg::NUM_DOMAINS{scan_mode}} | ~m_gate))
    else report_mismatch($sformatf("o_clk_en %b, gate bits %b", o_clk_en, m_gate));
  a_pmc_state : assert property (@(posedge pclk) disable iff (reset)
    {o_isolate_mem, o_pcm_irq} == {m_iso, m_wirq})
    else report_mismatch($sformatf("isolate_mem %b pcm_irq %b, expected %b %b",
                                   o_isolate_mem, o_pcm_irq, m_iso, m_wirq));

  // --------------------
  // Stimulus tasks
  // --------------------
  // Entered and left 1 ns after a rising edge
  task automatic apb_transfer(logic [31:0] addr, logic wr, logic [31:0] data, int waits);
    int waited;
    paddr = addr;                          // Setup phase
    pwrite = wr;
    pwdata = data;
    psel = 1'b1;
    penable = 1'b0;
    slot_pready = '1;
    if (waits > 0) slot_pready[addr[19:16]] = 1'b0;   // Only the addressed slot stalls
    @(posedge pclk);
    #1 penable = 1'b1;
    waited = 0;
    @(posedge pclk);
    while (!o_pready) begin
      waited++;
      #1;
      if (waited >= waits) slot_pready = '1;   // Slot releases the bus
      @(posedge pclk);
    end
    #1;
    psel = 1'b0;
    penable = 1'b0;
    assert (waited == waits)
      else report_mismatch($sformatf("o_pready low %0d cycles, slot held it %0d",
                                     waited, waits));
  endtask

  task automatic apb_read(logic [31:0] addr);
    apb_transfer(addr, 1'b0, '0, 0);
  endtask

  task automatic apb_write(logic [31:0] addr, logic [31:0] data);
    apb_transfer(addr, 1'b1, data, 0);
  endtask

  task automatic idle(int n);
    repeat (n) @(posedge pclk);
    #1;
  endtask

  task automatic pulse_irq(logic [pwr_pkg::NUM_IRQ-1:0] bits);
    irq = bits;
    idle(1);
    irq = '0;
    idle(1);
  endtask

  task automatic begin_test();
    test_num++;
    errors_at_start = errors;
  endtask

  task automatic end_test(string name);
    if (errors == errors_at_start) begin
      $display("Test %0d %s: passed", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED, %0d errors", test_num, name, errors - errors_at_start);
    end
  endtask

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge pclk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Errors found");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int          ext_slots[6];
    logic [31:0] rnd;
    ext_slots = '{soc_map_pkg::SLOT_SPI, soc_map_pkg::SLOT_UART0, soc_map_pkg::SLOT_GPIO,
                  soc_map_pkg::SLOT_TTC, soc_map_pkg::SLOT_SMC, soc_map_pkg::SLOT_UART1};
    pclk = 1'b0;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    slot_pready = '1;
    irq = '0;
    macb_wakeup = '0;
    scan_mode = 1'b0;
    errors = 0;
    test_num = 0;
    tests_failed = 0;
    lcg_state = 32'd56477;
    repeat (4) @(posedge pclk);
    #1 reset = 1'b0;

    begin_test();                          // Every slot once including holes
    for (int s = 0; s < soc_map_pkg::NUM_SLOTS; s++) begin
      rnd = lcg_next();
      apb_read(slot_addr(s, rnd[15:0] & 16'hFFFC));
    end
    apb_write(slot_addr(soc_map_pkg::SLOT_GPIO, 16'h0010), lcg_next());
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS));
    end_test("slot decode");

    begin_test();                          // Errors then stretched accesses
    apb_read(32'h0090_0000);
    apb_read(32'hFFFF_0004);
    apb_read(slot_addr(9 + int'(lcg_next() % 32'd7), 16'h0020));
    apb_read(slot_addr(15, 16'h0000));
    for (int i = 0; i < 4; i++) begin
      rnd = lcg_next();
      apb_transfer(slot_addr(ext_slots[int'(rnd % 32'd6)], 16'h0008), 1'b0, '0,
                   1 + int'(lcg_next() % 32'd4));
    end
    end_test("error response and wait states");

    begin_test();
    for (int b = 0; b < soc_map_pkg::LANES; b++) begin
      apb_read(slot_addr(soc_map_pkg::SLOT_UART0, 16'h0010 | 16'(b)));
    end
    rnd = lcg_next();
    apb_write(slot_addr(soc_map_pkg::SLOT_UART1, rnd[15:0]), lcg_next());
    end_test("byte lanes");

    begin_test();
    apb_write(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS), 32'h0000_002D);
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS));
    idle(2);
    scan_mode = 1'b1;                      // All enables forced on
    idle(3);
    scan_mode = 1'b0;
    idle(2);
    apb_write(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS), 32'h0);
    idle(2);
    end_test("gate control and scan");

    begin_test();
    apb_write(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS), 32'h0000_003F);
    pulse_irq(12'h001);                    // SPI wakes from sleep
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS));
    apb_write(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS), 32'h0000_013F);
    pulse_irq(12'h080);                    // DMA ignored in hibernation
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS));
    pulse_irq(12'(1) << pwr_pkg::IRQ_GPIO);
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS));
    end_test("wake rules");

    begin_test();
    apb_write(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS), 32'h0000_003C);
    macb_wakeup = 4'b0010;                 // Second MAC on a gated domain
    idle(1);
    macb_wakeup = '0;
    idle(1);
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_STAT_OFS));
    apb_write(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_STAT_OFS), 32'h1);
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_STAT_OFS));
    apb_read(slot_addr(soc_map_pkg::SLOT_PMC, pwr_pkg::PMC_CTRL_OFS));
    end_test("Ethernet wake interrupt");

    idle(2);
    $display("Tests run: %0d, failed: %0d, errors: %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/soc_map_pkg.sv
verilog/pwr_pkg.sv
verilog/apb_slave_if.sv
verilog/apb_slot_mux.sv
verilog/power_ctrl.sv
verilog/clk_gate_bank.sv
verilog/apb_subsystem.sv
verif/tb_apb_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_apb_subsystem \
  -f sources.f \
  -Mdir obj_dir -o sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
